/* src.f */
+incdir+common
common/renamePkg.sv
rename/priorityEncoder.sv
rename/tagBuffer.sv
rename/renameMap.sv
rename/renameControl.sv
verilog/renameTop.sv
dv/renameTb.sv

/* dv/renameTb.sv */
`timescale 1ns/1ps
`include "rename_settings.svh"

module renameTb;

    localparam int clkPeriod = 40;
    localparam int randomCycles = 300;
    localparam int exhaustCycles = 24;
    localparam int misprCycles = 300;
    localparam int runCycles = 5 + 20 + randomCycles + exhaustCycles + misprCycles;
    localparam int tagMsb = $bits(renamePkg::Tag) - 1;
    localparam renamePkg::Tag elimTag = {1'b1, {$bits(renamePkg::RFTag){1'b0}}};

    logic clk;
    logic rst;
    logic mispr;
    renamePkg::RenameReq renameReq[`NUM_ISSUE];
    renamePkg::CommitSlot commit[`NUM_COMMIT];
    renamePkg::RenameRes renameRes[`NUM_ISSUE];
    logic tagsReady;

    // reference model of the rename stage, advanced once per rising edge.
    logic [`NUM_TAGS-1:0] specFree;
    logic [`NUM_TAGS-1:0] comFree;
    renamePkg::Tag specMap[`NUM_ARCH_REGS];
    renamePkg::Tag comMap[`NUM_ARCH_REGS];
    renamePkg::RFTag slotTag[`NUM_ISSUE];
    logic slotValid[`NUM_ISSUE];
    logic refillWait;
    int recoverCnt;
    logic modelLive;
    renamePkg::RenameRes expRes[`NUM_ISSUE];
    renamePkg::CommitSlot commitQueue[$];
    renamePkg::RenameReq planned[`NUM_ISSUE];
    integer seed;
    string testName;

    renameTop renameTop_inst (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .renameReq(renameReq),
        .commit(commit),
        .renameRes(renameRes),
        .tagsReady(tagsReady)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    task automatic reportError(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic renames(renamePkg::RenameReq q);
        return q.valid && !mispr && q.dstValid && (q.dst != '0);
    endfunction

    // the youngest older slot of this group that writes the register wins over the map.
    function automatic renamePkg::Tag lookup(renamePkg::ArchReg r, int slot);
        renamePkg::Tag t;
        t = specMap[r];
        for (int j = 0; j < slot; j++) begin
            if (renames(renameReq[j]) && (renameReq[j].dst == r)) begin
                t = {1'b0, slotTag[j]};
            end
        end
        return t;
    endfunction

    function automatic renamePkg::RenameRes expectedResult(int slot);
        renamePkg::RenameRes r;
        r.valid = renameReq[slot].valid && !mispr;
        r.dstTag = renames(renameReq[slot]) ? {1'b0, slotTag[slot]} : elimTag;
        r.prevTag = lookup(renameReq[slot].dst, slot);
        r.src0Tag = lookup(renameReq[slot].src0, slot);
        r.src1Tag = lookup(renameReq[slot].src1, slot);
        return r;
    endfunction

    function automatic logic readyModel();
        logic ready;
        ready = !mispr && (recoverCnt == 0);
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            ready = ready && slotValid[i];
        end
        return ready;
    endfunction

    task automatic modelStep();
        renamePkg::RFTag lowTag[`NUM_ISSUE];
        renamePkg::CommitSlot entry;
        renamePkg::Tag prev;
        logic newest;
        int found;

        if (rst) begin
            specFree = '1;
            comFree = '1;
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                specMap[r] = elimTag;
                comMap[r] = elimTag;
            end
            for (int i = 0; i < `NUM_ISSUE; i++) begin
                slotValid[i] = 1'b0;
                expRes[i] = '0;
            end
            refillWait = 1'b0;
            recoverCnt = 0;
            modelLive = 1'b1;
        end else begin
            // refill uses the free list as it stood before this edge.
            found = 0;
            for (int b = 0; b < `NUM_TAGS; b++) begin
                if (specFree[b] && (found < `NUM_ISSUE)) begin
                    lowTag[found] = renamePkg::RFTag'(b);
                    found++;
                end
            end
            for (int i = 0; i < `NUM_ISSUE; i++) begin
                expRes[i] = expectedResult(i);
            end
            for (int i = 0; i < `NUM_ISSUE; i++) begin
                if (renames(renameReq[i])) begin
                    specMap[renameReq[i].dst] = {1'b0, slotTag[i]};
                    slotValid[i] = 1'b0;
                end
                if (expRes[i].valid && renameReq[i].dstValid) begin
                    entry.valid = 1'b1;
                    entry.dst = renameReq[i].dst;
                    entry.tagDst = expRes[i].dstTag;
                    commitQueue.push_back(entry);
                end
            end
            for (int i = 0; i < `NUM_ISSUE; i++) begin
                if (mispr) begin
                    slotValid[i] = 1'b0;
                end else if (!slotValid[i] && !refillWait && (i < found)) begin
                    slotTag[i] = lowTag[i];
                    slotValid[i] = 1'b1;
                    specFree[lowTag[i]] = 1'b0;
                end
            end
            for (int i = 0; i < `NUM_COMMIT; i++) begin
                if (commit[i].valid) begin
                    newest = 1'b1;
                    for (int j = i + 1; j < `NUM_COMMIT; j++) begin
                        if (commit[j].valid && (commit[j].dst == commit[i].dst)) begin
                            newest = 1'b0;
                        end
                    end
                    if (newest) begin
                        prev = comMap[commit[i].dst];
                        if (!prev[tagMsb]) begin
                            specFree[renamePkg::RFTag'(prev)] = 1'b1;
                            comFree[renamePkg::RFTag'(prev)] = 1'b1;
                        end
                        if (!commit[i].tagDst[tagMsb]) begin
                            specFree[renamePkg::RFTag'(commit[i].tagDst)] = 1'b0;
                            comFree[renamePkg::RFTag'(commit[i].tagDst)] = 1'b0;
                        end
                        comMap[commit[i].dst] = commit[i].tagDst;
                    end else if (!commit[i].tagDst[tagMsb]) begin
                        specFree[renamePkg::RFTag'(commit[i].tagDst)] = 1'b1;
                        comFree[renamePkg::RFTag'(commit[i].tagDst)] = 1'b1;
                    end
                end
            end
            if (mispr) begin
                specFree = comFree;
                for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                    specMap[r] = comMap[r];
                end
                recoverCnt = 2;
            end else if (recoverCnt > 0) begin
                recoverCnt = recoverCnt - 1;
            end
            refillWait = mispr;
        end
    endtask

    // one clock edge: advance the model, then drive the next inputs.
    task automatic step(input logic wantReq, input logic wantMispr, input int maxCommits,
                        output logic sent);
        logic doMispr;
        int n;

        @(posedge clk);
        modelStep();
        doMispr = wantMispr && !mispr && (recoverCnt == 0);
        sent = wantReq && !doMispr && (recoverCnt == 0);
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            sent = sent && slotValid[i];
        end
        n = $unsigned($random(seed)) % (maxCommits + 1);
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            renameReq[i] <= sent ? planned[i] : '0;
        end
        for (int i = 0; i < `NUM_COMMIT; i++) begin
            if ((i < n) && (commitQueue.size() > 0)) begin
                commit[i] <= commitQueue.pop_front();
            end else begin
                commit[i] <= '0;
            end
        end
        mispr <= doMispr;
        // everything still in flight is on the wrong path.
        if (doMispr) begin
            commitQueue.delete();
        end
    endtask

    task automatic issueGroup();
        logic sent;
        sent = 1'b0;
        while (!sent) begin
            step(1'b1, 1'b0, `NUM_COMMIT, sent);
        end
    endtask

    function automatic renamePkg::RenameReq makeReq(int dst, int src0, int src1, logic dstValid);
        renamePkg::RenameReq q;
        q.valid = 1'b1;
        q.dst = renamePkg::ArchReg'(dst);
        q.src0 = renamePkg::ArchReg'(src0);
        q.src1 = renamePkg::ArchReg'(src1);
        q.dstValid = dstValid;
        return q;
    endfunction

    function automatic renamePkg::RenameReq randomReq(int dstRange, logic dense);
        renamePkg::RenameReq q;
        logic [31:0] r;
        r = $random(seed);
        q.valid = dense || (r[2:0] != 3'd0);
        q.dstValid = dense || (r[5:3] != 3'd0);
        if (dense) begin
            q.dst = renamePkg::ArchReg'(1 + (r[15:8] % (`NUM_ARCH_REGS - 1)));
        end else begin
            q.dst = renamePkg::ArchReg'(r[15:8] % dstRange);
        end
        q.src0 = renamePkg::ArchReg'(r[23:16] % `NUM_ARCH_REGS);
        q.src1 = renamePkg::ArchReg'(r[31:24] % `NUM_ARCH_REGS);
        return q;
    endfunction

    task automatic runRandom(input int cycles, input int dstRange, input logic dense,
                             input int maxCommits, input int misprOdds);
        logic sent;
        logic wantMispr;
        for (int c = 0; c < cycles; c++) begin
            for (int i = 0; i < `NUM_ISSUE; i++) begin
                planned[i] = randomReq(dstRange, dense);
            end
            wantMispr = (misprOdds > 0) && (($unsigned($random(seed)) % misprOdds) == 0);
            step(1'b1, wantMispr, maxCommits, sent);
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (modelLive) begin
                for (int i = 0; i < `NUM_ISSUE; i++) begin
                    if (expRes[i].valid) begin
                        assert (renameRes[i] === expRes[i]) else reportError($sformatf(
                            "error %s: renameRes[%0d] expected %h actual %h",
                            testName, i, expRes[i], renameRes[i]));
                    end else begin
                        assert (renameRes[i].valid === 1'b0) else reportError($sformatf(
                            "error %s: renameRes[%0d].valid expected 0 actual %b",
                            testName, i, renameRes[i].valid));
                    end
                end
                assert (tagsReady === readyModel()) else reportError($sformatf(
                    "error %s: tagsReady expected %b actual %b",
                    testName, readyModel(), tagsReady));
            end
        end
    end

    initial begin
        #((runCycles + 200) * clkPeriod);
        reportError("timeout: the regression did not reach its end in time");
    end

    initial begin
        logic sent;

        seed = 32'h3be0d514;
        modelLive = 1'b0;
        rst = 1'b1;
        mispr = 1'b0;
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            renameReq[i] = '0;
        end
        for (int i = 0; i < `NUM_COMMIT; i++) begin
            commit[i] = '0;
        end
        testName = "reset";
        repeat (5) begin
            @(posedge clk);
            modelStep();
        end
        rst <= 1'b0;

        testName = "firstGroup";
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            planned[i] = makeReq(i + 1, i, 0, 1'b1);
        end
        issueGroup();
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            planned[i] = makeReq(i + 5, i + 1, i + 2, 1'b1);
        end
        issueGroup();

        testName = "forwarding";
        planned[0] = makeReq(3, 1, 2, 1'b1);
        planned[1] = makeReq(5, 3, 3, 1'b1);
        planned[2] = makeReq(3, 5, 3, 1'b1);
        planned[3] = makeReq(6, 3, 5, 1'b1);
        issueGroup();

        testName = "elimination";
        planned[0] = makeReq(0, 3, 0, 1'b1);
        planned[1] = makeReq(7, 0, 6, 1'b0);
        planned[2] = makeReq(0, 0, 0, 1'b1);
        planned[3] = makeReq(8, 0, 7, 1'b1);
        issueGroup();

        // a narrow register range makes same-cycle commits to one dst common.
        testName = "randomCommit";
        runRandom(randomCycles, 6, 1'b0, `NUM_COMMIT, 0);

        testName = "exhaust";
        runRandom(exhaustCycles, `NUM_ARCH_REGS, 1'b1, 0, 0);
        @(negedge clk);
        assert (tagsReady === 1'b0) else reportError($sformatf(
            "error %s: tagsReady expected 0 actual %b", testName, tagsReady));

        testName = "mispredict";
        runRandom(misprCycles, `NUM_ARCH_REGS, 1'b0, `NUM_COMMIT, 12);

        testName = "idle";
        step(1'b0, 1'b0, 0, sent);
        step(1'b0, 1'b0, 0, sent);
        $display("Regression passed");
        $finish;
    end

endmodule

/* verilog/renameTop.sv */
`timescale 1ns/1ps
`include "rename_settings.svh"

module renameTop (
    input logic clk,
    input logic rst,
    input logic mispr,
    input renamePkg::RenameReq renameReq[`NUM_ISSUE],
    input renamePkg::CommitSlot commit[`NUM_COMMIT],
    output renamePkg::RenameRes renameRes[`NUM_ISSUE],
    output logic tagsReady
);

    logic issueValid[`NUM_ISSUE];
    logic write[`NUM_ISSUE];
    logic commitNewest[`NUM_COMMIT];
    renamePkg::RFTag issueTags[`NUM_ISSUE];
    logic issueTagsValid[`NUM_ISSUE];
    renamePkg::Tag commitPrevTags[`NUM_COMMIT];

    renameControl control (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .req(renameReq),
        .issueTagsValid(issueTagsValid),
        .commit(commit),
        .issueValid(issueValid),
        .write(write),
        .commitNewest(commitNewest),
        .tagsReady(tagsReady)
    );

    tagBuffer tags (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .issueValid(issueValid),
        .issueTags(issueTags),
        .issueTagsValid(issueTagsValid),
        .commit(commit),
        .commitNewest(commitNewest),
        .commitPrevTags(commitPrevTags)
    );

    renameMap map (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .req(renameReq),
        .write(write),
        .newTags(issueTags),
        .res(renameRes),
        .commit(commit),
        .commitNewest(commitNewest),
        .commitPrevTags(commitPrevTags)
    );

endmodule

/* rename/renameControl.sv */
`timescale 1ns/1ps
`include "rename_settings.svh"

module renameControl (
    input logic clk,
    input logic rst,
    input logic mispr,

    input renamePkg::RenameReq req[`NUM_ISSUE],
    input logic issueTagsValid[`NUM_ISSUE],
    input renamePkg::CommitSlot commit[`NUM_COMMIT],

    output logic issueValid[`NUM_ISSUE],
    output logic write[`NUM_ISSUE],
    output logic commitNewest[`NUM_COMMIT],
    output logic tagsReady
);

    // counts down the two cycles in which the slots refill after a mispredict.
    logic [1:0] recover;
    logic allValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            recover <= 2'd0;
        end else if (mispr) begin
            recover <= 2'd2;
        end else if (recover != 2'd0) begin
            recover <= recover - 2'd1;
        end
    end

    always_comb begin
        allValid = 1'b1;
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            if (!issueTagsValid[i]) begin
                allValid = 1'b0;
            end
        end
    end

    assign tagsReady = allValid && !mispr && (recover == 2'd0);

    // writes to register 0 or without a destination are eliminated and take no tag.
    always_comb begin
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            write[i] = req[i].valid && !mispr;
            issueValid[i] = req[i].valid && !mispr && req[i].dstValid && (req[i].dst != '0);
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_COMMIT; i++) begin
            commitNewest[i] = commit[i].valid;
            for (int j = i + 1; j < `NUM_COMMIT; j++) begin
                if (commit[j].valid && (commit[j].dst == commit[i].dst)) begin
                    commitNewest[i] = 1'b0;
                end
            end
        end
    end

    for (genvar i = 0; i < `NUM_ISSUE; i++) begin : gReqCheck
        reqOnlyWhenReady: assert property (
            @(posedge clk) disable iff (rst) req[i].valid |-> tagsReady
        );
    end

endmodule

/* rename/renameMap.sv */
`timescale 1ns/1ps
`include "rename_settings.svh"

module renameMap (
    input logic clk,
    input logic rst,
    input logic mispr,

    input renamePkg::RenameReq req[`NUM_ISSUE],
    input logic write[`NUM_ISSUE],
    input renamePkg::RFTag newTags[`NUM_ISSUE],
    output renamePkg::RenameRes res[`NUM_ISSUE],

    input renamePkg::CommitSlot commit[`NUM_COMMIT],
    input logic commitNewest[`NUM_COMMIT],
    output renamePkg::Tag commitPrevTags[`NUM_COMMIT]
);

    localparam renamePkg::Tag elimTag = {1'b1, {$bits(renamePkg::RFTag){1'b0}}};

    renamePkg::Tag specMap[`NUM_ARCH_REGS];
    renamePkg::Tag comMap[`NUM_ARCH_REGS];

    logic renamed[`NUM_ISSUE];
    renamePkg::RenameRes resNext[`NUM_ISSUE];

    always_comb begin
        for (int i = 0; i < `NUM_COMMIT; i++) begin
            commitPrevTags[i] = comMap[commit[i].dst];
        end
    end

    // older slots in the same group win over the map, the youngest older slot last.
    always_comb begin
        for (int i = 0; i < `NUM_ISSUE; i++) begin
            renamed[i] = write[i] && req[i].dstValid && (req[i].dst != '0);
        end

        for (int i = 0; i < `NUM_ISSUE; i++) begin
            resNext[i].valid = write[i];
            resNext[i].dstTag = renamed[i] ? {1'b0, newTags[i]} : elimTag;
            resNext[i].prevTag = specMap[req[i].dst];
            resNext[i].src0Tag = specMap[req[i].src0];
            resNext[i].src1Tag = specMap[req[i].src1];
            for (int j = 0; j < i; j++) begin
                if (renamed[j]) begin
                    if (req[j].dst == req[i].dst) begin
                        resNext[i].prevTag = {1'b0, newTags[j]};
                    end
                    if (req[j].dst == req[i].src0) begin
                        resNext[i].src0Tag = {1'b0, newTags[j]};
                    end
                    if (req[j].dst == req[i].src1) begin
                        resNext[i].src1Tag = {1'b0, newTags[j]};
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                specMap[r] <= elimTag;
                comMap[r] <= elimTag;
            end
            for (int i = 0; i < `NUM_ISSUE; i++) begin
                res[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `NUM_ISSUE; i++) begin
                res[i] <= resNext[i];
            end

            if (mispr) begin
                for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                    specMap[r] <= comMap[r];
                end
            end else begin
                for (int i = 0; i < `NUM_ISSUE; i++) begin
                    if (renamed[i]) begin
                        specMap[req[i].dst] <= {1'b0, newTags[i]};
                    end
                end
            end

            for (int i = 0; i < `NUM_COMMIT; i++) begin
                if (commitNewest[i]) begin
                    comMap[commit[i].dst] <= commit[i].tagDst;
                    // the restored map has to include this cycle's commits as well.
                    if (mispr) begin
                        specMap[commit[i].dst] <= commit[i].tagDst;
                    end
                end
            end
        end
    end

endmodule

/* rename/tagBuffer.sv */
`timescale 1ns/1ps
`include "rename_settings.svh"

module tagBuffer (
    input logic clk,
    input logic rst,
    input logic mispr,

    input logic issueValid[`NUM_ISSUE],
    output renamePkg::RFTag issueTags[`NUM_ISSUE],
    output logic issueTagsValid[`NUM_ISSUE],

    input renamePkg::CommitSlot commit[`NUM_COMMIT],
    input logic commitNewest[`NUM_COMMIT],
    input renamePkg::Tag commitPrevTags[`NUM_COMMIT]
);

    localparam int tagMsb = $bits(renamePkg::Tag) - 1;

    // speculative and committed free lists, one bit per physical register.
    logic [`NUM_TAGS-1:0] free;
    logic [`NUM_TAGS-1:0] freeCom;

    logic mispredWait;

    renamePkg::RFTag encIdx[`NUM_ISSUE];
    logic encIdxValid[`NUM_ISSUE];

    priorityEncoder penc (
        .data(free),
        .idx(encIdx),
        .idxValid(encIdxValid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            free <= '1;
            freeCom <= '1;
            mispredWait <= 1'b0;
            for (int i = 0; i < `NUM_ISSUE; i++) begin
                issueTagsValid[i] <= 1'b0;
            end
        end else begin
            mispredWait <= mispr;

            if (mispr) begin
                // tags sitting in the slots are free in the committed list, so they return too.
                free <= freeCom;
                for (int i = 0; i < `NUM_ISSUE; i++) begin
                    issueTagsValid[i] <= 1'b0;
                end
            end else begin
                for (int i = 0; i < `NUM_ISSUE; i++) begin
                    if (issueValid[i]) begin
                        issueTagsValid[i] <= 1'b0;
                    end

                    // slot i takes the i-th lowest free tag when it is empty or used up.
                    if ((!issueTagsValid[i] || issueValid[i]) && encIdxValid[i]
                            && !mispredWait) begin
                        issueTagsValid[i] <= 1'b1;
                        issueTags[i] <= encIdx[i];
                        free[encIdx[i]] <= 1'b0;
                    end
                end
            end

            // commits land after the copy above so that both lists see them.
            for (int i = 0; i < `NUM_COMMIT; i++) begin
                if (commit[i].valid) begin
                    if (commitNewest[i]) begin
                        if (!commitPrevTags[i][tagMsb]) begin
                            free[renamePkg::RFTag'(commitPrevTags[i])] <= 1'b1;
                            freeCom[renamePkg::RFTag'(commitPrevTags[i])] <= 1'b1;
                        end
                        if (!commit[i].tagDst[tagMsb]) begin
                            free[renamePkg::RFTag'(commit[i].tagDst)] <= 1'b0;
                            freeCom[renamePkg::RFTag'(commit[i].tagDst)] <= 1'b0;
                        end
                    end else if (!commit[i].tagDst[tagMsb]) begin
                        // a younger commit in this group overwrites the mapping.
                        free[renamePkg::RFTag'(commit[i].tagDst)] <= 1'b1;
                        freeCom[renamePkg::RFTag'(commit[i].tagDst)] <= 1'b1;
                    end
                end
            end
        end
    end

    for (genvar i = 0; i < `NUM_ISSUE; i++) begin : gSlotCheck
        slotHeldTag: assert property (
            @(posedge clk) disable iff (rst) issueValid[i] |-> issueTagsValid[i]
        );
    end

endmodule

/* rename/priorityEncoder.sv */
`timescale 1ns/1ps
`include "rename_settings.svh"

module priorityEncoder (
    input logic [`NUM_TAGS-1:0] data,
    output renamePkg::RFTag idx[`NUM_ISSUE],
    output logic idxValid[`NUM_ISSUE]
);

    // each output takes the lowest bit still set, then clears it for the next one.
    always_comb begin
        logic [`NUM_TAGS-1:0] remaining;

        remaining = data;
        for (int k = 0; k < `NUM_ISSUE; k++) begin
            idx[k] = '0;
            idxValid[k] = 1'b0;

            // scanning downwards leaves the lowest set position as the final hit.
            for (int b = `NUM_TAGS - 1; b >= 0; b--) begin
                if (remaining[b]) begin
                    idx[k] = renamePkg::RFTag'(b);
                    idxValid[k] = 1'b1;
                end
            end

            if (idxValid[k]) begin
                remaining[idx[k]] = 1'b0;
            end
        end
    end

endmodule

/* common/renamePkg.sv */
`include "rename_settings.svh"

package renamePkg;

    // index of a physical register.
    typedef logic [$clog2(`NUM_TAGS)-1:0] RFTag;

    // a set top bit marks an eliminated value that has no physical register.
    typedef logic [$clog2(`NUM_TAGS):0] Tag;

    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] ArchReg;

    typedef struct packed {
        logic valid;
        ArchReg dst;
        ArchReg src0;
        ArchReg src1;
        logic dstValid;
    } RenameReq;

    typedef struct packed {
        logic valid;
        Tag dstTag;
        Tag prevTag;
        Tag src0Tag;
        Tag src1Tag;
    } RenameRes;

    typedef struct packed {
        logic valid;
        ArchReg dst;
        Tag tagDst;
    } CommitSlot;

endpackage

/* common/rename_settings.svh */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// physical registers behind the rename stage.
`define NUM_TAGS 32

// architectural registers visible to the front end.
`define NUM_ARCH_REGS 16

// rename and commit slots per cycle.
`define NUM_ISSUE 4
`define NUM_COMMIT 4

`endif
